//--- source/sprite_cfg.svh
`ifndef SPRITE_CFG_SVH
`define SPRITE_CFG_SVH

// number of hardware sprite lanes.
`define SPRITE_N 4

// screen coordinate width, shared by x and y.
`define SPRITE_W_COORD 10

// byte address width of the tile memory bus.
`define SPRITE_W_ADDR 32

// The largest row is 16 pixels at 8 bits per pixel, which is four 32-bit words.
`define SPRITE_ROW_WORDS 4

`endif

//--- source/sprite_pkg.sv
`include "sprite_cfg.svh"

package sprite_pkg;

	typedef struct packed {
		logic [`SPRITE_W_COORD-1:0] pos_x;  // left column of the sprite.
		logic [`SPRITE_W_COORD-1:0] pos_y;  // top line of the sprite.
		logic [7:0]                 tile;
	} sprite_cfg_t;

	typedef struct packed {
		logic [23:0] tmbase;    // tile memory base in 256-byte units.
		logic        tilesize;  // 0 is 8 pixels square, 1 is 16.
		logic        pixmode;   // 0 is 4bpp, 1 is 8bpp.
	} layer_cfg_t;

	// answer to one lane's line test.
	typedef struct packed {
		logic       active;
		logic [3:0] row;
	} coord_res_t;

	typedef struct packed {
		logic [3:0]                          row;
		logic [$clog2(`SPRITE_ROW_WORDS)-1:0] word;
	} fetch_req_t;

	typedef struct packed {
		logic                      vld;
		logic [`SPRITE_W_ADDR-1:0] addr;
	} bus_req_t;

	// One fetched word holds eight 4bpp pixels or four 8bpp pixels, lowest field first.
	typedef union packed {
		logic [7:0][3:0] p4;
		logic [3:0][7:0] p8;
	} pix_word_u;

	typedef struct packed {
		logic       opaque;
		logic [7:0] color;
	} lane_pix_t;

	typedef struct packed {
		logic                         hit;
		logic [$clog2(`SPRITE_N)-1:0] index;  // lane that won the pixel.
		logic [7:0]                   color;
	} pix_out_t;

endpackage

//--- source/sprite_agu.sv
`timescale 1ns/1ps
`include "sprite_cfg.svh"

module sprite_agu (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [`SPRITE_W_COORD-1:0] line_y,
	input  sprite_pkg::sprite_cfg_t    sprite_cfg [`SPRITE_N],
	input  sprite_pkg::layer_cfg_t     layer_cfg,
	input  logic [`SPRITE_N-1:0]       coord_req,
	output logic [`SPRITE_N-1:0]       coord_ack,
	output sprite_pkg::coord_res_t     coord_res,
	input  logic [`SPRITE_N-1:0]       fetch_vld,
	input  sprite_pkg::fetch_req_t     fetch_req [`SPRITE_N],
	output logic [`SPRITE_N-1:0]       fetch_rdy,
	output logic [31:0]                fetch_data,
	output sprite_pkg::bus_req_t       bus_req,
	input  logic                       bus_rdy,
	input  logic [31:0]                bus_data
);

	logic [4:0]                 tile_px;
	logic [`SPRITE_N-1:0]       coord_gnt;
	logic [`SPRITE_W_COORD-1:0] coord_pos_y;
	logic [`SPRITE_W_COORD-1:0] line_dy;

	logic [`SPRITE_N-1:0]       fetch_gnt_comb;
	logic [`SPRITE_N-1:0]       fetch_gnt_q;
	logic [`SPRITE_N-1:0]       fetch_gnt;
	sprite_pkg::fetch_req_t     bus_fetch;
	logic [7:0]                 bus_tile;
	logic [2:0]                 log_row_bytes;
	logic [3:0]                 log_tile_bytes;

	assign tile_px = layer_cfg.tilesize ? 5'd16 : 5'd8;

	// Line test. The lowest requesting lane wins and is acked in the same cycle.
	assign coord_gnt = coord_req & (~coord_req + 1'b1);
	assign coord_ack = coord_gnt;

	always_comb begin
		coord_pos_y = '0;
		for (int i = 0; i < `SPRITE_N; i++) begin
			if (coord_gnt[i])
				coord_pos_y |= sprite_cfg[i].pos_y;
		end
	end

	assign line_dy = line_y - coord_pos_y;  // wraps when the line is above the sprite.
	assign coord_res.active = (line_y >= coord_pos_y) &&
		(line_dy < `SPRITE_W_COORD'(tile_px));
	assign coord_res.row = line_dy[3:0];

	// Fetch arbitration. Once a lane holds the bus it keeps it until the memory answers.
	assign fetch_gnt_comb = fetch_vld & (~fetch_vld + 1'b1);
	assign fetch_gnt = |fetch_gnt_q ? fetch_gnt_q : fetch_gnt_comb;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			fetch_gnt_q <= '0;
		else if (bus_rdy)
			fetch_gnt_q <= '0;
		else if (!(|fetch_gnt_q))
			fetch_gnt_q <= fetch_gnt_comb;  // lock the grant while the bus stalls.
	end

	always_comb begin
		bus_fetch = '0;
		bus_tile = '0;
		for (int i = 0; i < `SPRITE_N; i++) begin
			if (fetch_gnt[i]) begin
				bus_fetch |= fetch_req[i];
				bus_tile |= sprite_cfg[i].tile;
			end
		end
	end

	// row bytes are 4, 8 or 16, and a tile is the size times the row bytes.
	assign log_row_bytes = 3'd2 + 3'(layer_cfg.tilesize) + 3'(layer_cfg.pixmode);
	assign log_tile_bytes = 4'(log_row_bytes) + 4'd3 + 4'(layer_cfg.tilesize);

	assign bus_req.vld = |fetch_gnt;
	assign bus_req.addr = `SPRITE_W_ADDR'({layer_cfg.tmbase, 8'h00})
		+ (`SPRITE_W_ADDR'(bus_tile) << log_tile_bytes)
		+ (`SPRITE_W_ADDR'(bus_fetch.row) << log_row_bytes)
		+ (`SPRITE_W_ADDR'(bus_fetch.word) << 2);

	// the word is handed back in the cycle the memory completes the transfer.
	assign fetch_rdy = fetch_gnt & {`SPRITE_N{bus_rdy}};
	assign fetch_data = bus_data;

endmodule

//--- source/sprite_lane.sv
`timescale 1ns/1ps
`include "sprite_cfg.svh"

module sprite_lane (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       line_start,
	input  sprite_pkg::sprite_cfg_t    sprite_cfg,
	input  sprite_pkg::layer_cfg_t     layer_cfg,
	output logic                       coord_req,
	input  logic                       coord_ack,
	input  sprite_pkg::coord_res_t     coord_res,
	output logic                       fetch_vld,
	output sprite_pkg::fetch_req_t     fetch_req,
	input  logic                       fetch_rdy,
	input  logic [31:0]                fetch_data,
	input  logic [`SPRITE_W_COORD-1:0] pix_x,
	output logic                       busy,
	output sprite_pkg::lane_pix_t      lane_pix
);

	localparam int W_WORD = $clog2(`SPRITE_ROW_WORDS);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_TEST,
		ST_FETCH,
		ST_DONE
	} state_t;

	state_t                     state;
	logic                       act_q;
	logic [3:0]                 row_q;
	logic [W_WORD-1:0]          word_q;
	logic [W_WORD-1:0]          last_word;
	sprite_pkg::pix_word_u      row_buf [`SPRITE_ROW_WORDS];

	logic [4:0]                 tile_px;
	logic [`SPRITE_W_COORD-1:0] off_x;
	logic                       in_range;
	logic [3:0]                 u;
	logic [W_WORD-1:0]          rd_word;
	sprite_pkg::pix_word_u      rd_pix;
	logic [7:0]                 color;

	// A row is 1, 2 or 4 words depending on size and pixel depth.
	assign last_word = W_WORD'({layer_cfg.tilesize & layer_cfg.pixmode,
		layer_cfg.tilesize | layer_cfg.pixmode});

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			act_q <= 1'b0;
			row_q <= '0;
			word_q <= '0;
		end else if (line_start) begin
			state <= ST_TEST;
			act_q <= 1'b0;  // no pixels from the old line while testing the new one.
			word_q <= '0;
		end else begin
			case (state)
				ST_TEST: begin
					if (coord_ack) begin
						act_q <= coord_res.active;
						row_q <= coord_res.row;
						state <= coord_res.active ? ST_FETCH : ST_DONE;
					end
				end
				ST_FETCH: begin
					if (fetch_rdy) begin
						if (word_q == last_word)
							state <= ST_DONE;
						else
							word_q <= word_q + 1'b1;
					end
				end
				default: begin
					state <= state;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_FETCH && fetch_rdy)
			row_buf[word_q] <= fetch_data;
	end

	assign coord_req = (state == ST_TEST);
	assign fetch_vld = (state == ST_FETCH);
	assign fetch_req.row = row_q;
	assign fetch_req.word = word_q;
	assign busy = coord_req | fetch_vld;

	// Pixel lookup. An x left of the sprite wraps to a large offset and fails the range test.
	assign tile_px = layer_cfg.tilesize ? 5'd16 : 5'd8;
	assign off_x = pix_x - sprite_cfg.pos_x;
	assign in_range = off_x < `SPRITE_W_COORD'(tile_px);
	assign u = off_x[3:0];

	assign rd_word = layer_cfg.pixmode ? W_WORD'(u[3:2]) : W_WORD'(u[3]);
	assign rd_pix = row_buf[rd_word];
	assign color = layer_cfg.pixmode ? rd_pix.p8[u[1:0]] : {4'h0, rd_pix.p4[u[2:0]]};

	assign lane_pix.opaque = act_q && in_range && (color != 8'h00);  // colour 0 is see-through.
	assign lane_pix.color = color;

endmodule

//--- source/sprite_blend.sv
`timescale 1ns/1ps
`include "sprite_cfg.svh"

module sprite_blend (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  pix_req,
	input  sprite_pkg::lane_pix_t lane_pix [`SPRITE_N],
	output logic                  pix_vld,
	output sprite_pkg::pix_out_t  pix_out
);

	localparam int W_IDX = $clog2(`SPRITE_N);

	sprite_pkg::pix_out_t pick;

	// Walk from the highest lane down so the lowest opaque lane is written last.
	always_comb begin
		pick = '0;
		for (int i = `SPRITE_N - 1; i >= 0; i--) begin
			if (lane_pix[i].opaque) begin
				pick.hit = 1'b1;
				pick.index = W_IDX'(i);
				pick.color = lane_pix[i].color;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pix_vld <= 1'b0;
		else
			pix_vld <= pix_req;  // one answer per query, one cycle later.
	end

	always_ff @(posedge clk) begin
		if (pix_req)
			pix_out <= pick;
	end

endmodule

//--- source/sprite_engine.sv
`timescale 1ns/1ps
`include "sprite_cfg.svh"

module sprite_engine (
	input  logic                       clk,
	input  logic                       rst_n,
	input  sprite_pkg::sprite_cfg_t    sprite_cfg [`SPRITE_N],
	input  sprite_pkg::layer_cfg_t     layer_cfg,
	input  logic                       line_start,
	input  logic [`SPRITE_W_COORD-1:0] line_y,
	input  logic                       pix_req,
	input  logic [`SPRITE_W_COORD-1:0] pix_x,
	output sprite_pkg::bus_req_t       bus_req,
	input  logic                       bus_rdy,
	input  logic [31:0]                bus_data,
	output logic                       line_ready,
	output logic                       pix_vld,
	output sprite_pkg::pix_out_t       pix_out
);

	logic [`SPRITE_N-1:0]   coord_req;
	logic [`SPRITE_N-1:0]   coord_ack;
	sprite_pkg::coord_res_t coord_res;
	logic [`SPRITE_N-1:0]   fetch_vld;
	logic [`SPRITE_N-1:0]   fetch_rdy;
	sprite_pkg::fetch_req_t fetch_req [`SPRITE_N];
	logic [31:0]            fetch_data;
	logic [`SPRITE_N-1:0]   busy;
	sprite_pkg::lane_pix_t  lane_pix [`SPRITE_N];
	logic                   line_seen;

	sprite_agu u_agu (
		.clk        (clk),
		.rst_n      (rst_n),
		.line_y     (line_y),
		.sprite_cfg (sprite_cfg),
		.layer_cfg  (layer_cfg),
		.coord_req  (coord_req),
		.coord_ack  (coord_ack),
		.coord_res  (coord_res),
		.fetch_vld  (fetch_vld),
		.fetch_req  (fetch_req),
		.fetch_rdy  (fetch_rdy),
		.fetch_data (fetch_data),
		.bus_req    (bus_req),
		.bus_rdy    (bus_rdy),
		.bus_data   (bus_data)
	);

	for (genvar k = 0; k < `SPRITE_N; k++) begin : g_lane
		sprite_lane u_lane (
			.clk        (clk),
			.rst_n      (rst_n),
			.line_start (line_start),
			.sprite_cfg (sprite_cfg[k]),
			.layer_cfg  (layer_cfg),
			.coord_req  (coord_req[k]),
			.coord_ack  (coord_ack[k]),
			.coord_res  (coord_res),
			.fetch_vld  (fetch_vld[k]),
			.fetch_req  (fetch_req[k]),
			.fetch_rdy  (fetch_rdy[k]),
			.fetch_data (fetch_data),
			.pix_x      (pix_x),
			.busy       (busy[k]),
			.lane_pix   (lane_pix[k])
		);
	end

	sprite_blend u_blend (
		.clk      (clk),
		.rst_n    (rst_n),
		.pix_req  (pix_req),
		.lane_pix (lane_pix),
		.pix_vld  (pix_vld),
		.pix_out  (pix_out)
	);

	// ready follows the lanes going quiet, but only once a line has been started.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			line_seen <= 1'b0;
			line_ready <= 1'b0;
		end else begin
			if (line_start)
				line_seen <= 1'b1;
			line_ready <= line_seen && !line_start && !(|busy);
		end
	end

endmodule

//--- bench/sprite_clkgen.sv
`timescale 1ns/1ps

module sprite_clkgen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;  // released on an edge after three cycles.
	end

	always #20 clk = ~clk;

endmodule

//--- bench/sprite_asserts.sv
`timescale 1ns/1ps
`include "sprite_cfg.svh"

module sprite_asserts (
	input logic                 clk,
	input logic                 rst_n,
	input sprite_pkg::bus_req_t bus_req,
	input logic                 bus_rdy,
	input logic [`SPRITE_N-1:0] coord_ack,
	input logic                 pix_req,
	input logic                 pix_vld
);

	int fail_count = 0;  // assertion failures seen so far.

	// a stalled request keeps one steady address until the memory answers.
	a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(bus_req.vld && !bus_rdy) |=> (bus_req.vld && $stable(bus_req.addr)))
		else begin
			$error("bus address moved while the request was stalled");
			fail_count++;
		end

	a_addr_align: assert property (@(posedge clk) disable iff (!rst_n)
		bus_req.vld |-> (bus_req.addr[1:0] == 2'b00))
		else begin
			$error("bus address is not word aligned");
			fail_count++;
		end

	a_ack_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(coord_ack))
		else begin
			$error("more than one lane acked in the same cycle");
			fail_count++;
		end

	a_pix_latency: assert property (@(posedge clk) disable iff (!rst_n)
		pix_vld == $past(pix_req))
		else begin
			$error("pix_vld does not follow pix_req by one cycle");
			fail_count++;
		end

endmodule

bind sprite_engine sprite_asserts u_asserts (
	.clk       (clk),
	.rst_n     (rst_n),
	.bus_req   (bus_req),
	.bus_rdy   (bus_rdy),
	.coord_ack (coord_ack),
	.pix_req   (pix_req),
	.pix_vld   (pix_vld)
);

//--- bench/sprite_tb.sv
`timescale 1ns/1ps
`include "sprite_cfg.svh"

module sprite_tb;

	localparam int LINE_CYCLES = 4 * 4 * 5 + 80;  // four lanes of four words, five cycles each.
	localparam int N_LINES = 8;

	logic                       clk;
	logic                       rst_n;
	sprite_pkg::sprite_cfg_t    sprite_cfg [`SPRITE_N];
	sprite_pkg::layer_cfg_t     layer_cfg;
	logic                       line_start;
	logic [`SPRITE_W_COORD-1:0] line_y;
	logic                       pix_req;
	logic [`SPRITE_W_COORD-1:0] pix_x;
	sprite_pkg::bus_req_t       bus_req;
	logic                       bus_rdy;
	logic [31:0]                bus_data;
	logic                       line_ready;
	logic                       pix_vld;
	sprite_pkg::pix_out_t       pix_out;

	integer                     seed = 32'h95ab4fbf;
	int                         stall = 0;
	int                         cycle = 0;
	int                         err_count = 0;
	int                         check_count = 0;
	int                         resp_count = 0;
	logic [31:0]                served [$];  // addresses the memory answered on this line.
	sprite_pkg::pix_out_t       exp_q [$];
	int                         cyc_q [$];

	sprite_clkgen u_clkgen (.clk(clk), .rst_n(rst_n));

	sprite_engine u_sprite_engine (.*);

	// every word has one byte cleared, so both pixel modes see transparent pixels.
	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		logic [31:0] w;
		w = (addr * 32'h9e3779b1) ^ (addr >> 3) ^ 32'h3c5a96e1;
		return w & ~(32'h000000ff << (8 * addr[3:2]));
	endfunction

	function automatic logic [31:0] rule_addr(input sprite_pkg::layer_cfg_t lc, input int tile,
		input int row, input int word);
		int size;
		int row_bytes;
		size = lc.tilesize ? 16 : 8;
		row_bytes = size * (lc.pixmode ? 8 : 4) / 8;
		return {lc.tmbase, 8'h00} + tile * size * row_bytes + row * row_bytes + word * 4;
	endfunction

	// row of the sprite on line y, or -1 when the sprite misses the line.
	function automatic int sprite_row(input sprite_pkg::sprite_cfg_t s,
		input sprite_pkg::layer_cfg_t lc, input int y);
		int dy;
		dy = y - int'(s.pos_y);
		return (dy >= 0 && dy < (lc.tilesize ? 16 : 8)) ? dy : -1;
	endfunction

	function automatic sprite_pkg::pix_out_t ref_pixel(input sprite_pkg::sprite_cfg_t sc [`SPRITE_N],
		input sprite_pkg::layer_cfg_t lc, input int y, input int x);
		sprite_pkg::pix_out_t r;
		int size;
		int bpp;
		int dy;
		int dx;
		int bit_pos;
		logic [31:0] data;
		logic [7:0] col;
		r = '0;
		size = lc.tilesize ? 16 : 8;
		bpp = lc.pixmode ? 8 : 4;
		for (int k = 0; k < `SPRITE_N; k++) begin
			dy = sprite_row(sc[k], lc, y);
			dx = x - int'(sc[k].pos_x);
			if (!r.hit && dy >= 0 && dx >= 0 && dx < size) begin
				bit_pos = dx * bpp;  // lowest field of a word holds the leftmost pixel.
				data = mem_word(rule_addr(lc, sc[k].tile, dy, bit_pos / 32));
				col = 8'((data >> (bit_pos % 32)) & ((32'd1 << bpp) - 1));
				if (col != 8'h00) begin
					r.hit = 1'b1;
					r.index = $bits(r.index)'(k);
					r.color = col;
				end
			end
		end
		return r;
	endfunction

	task automatic flag_mismatch(input string sig, input logic [31:0] got, input logic [31:0] exp);
		$display("CHECK FAILED t=%0t %s got 0x%0h expected 0x%0h", $time, sig, got, exp);
		err_count++;
	endtask

	task automatic flag_error(input string msg);
		$display("ERROR t=%0t %s", $time, msg);
		err_count++;
	endtask

	task set_layer(input bit ts, input bit pm);
		@(posedge clk);
		layer_cfg <= '{tmbase: 24'h000123, tilesize: ts, pixmode: pm};
		foreach (sprite_cfg[k])
			sprite_cfg[k] <= '{pos_x: 0, pos_y: 900, tile: 0};  // parked below the tested lines.
	endtask

	task place(input int k, input int x, input int y, input int t);
		sprite_cfg[k] <= '{pos_x: x, pos_y: y, tile: t};
	endtask

	task automatic check_served(input int y);
		logic [31:0] want [$];
		int dy;
		int nw;
		int hit;
		nw = (layer_cfg.tilesize ? 16 : 8) * (layer_cfg.pixmode ? 8 : 4) / 32;
		for (int k = 0; k < `SPRITE_N; k++) begin
			dy = sprite_row(sprite_cfg[k], layer_cfg, y);
			for (int w = 0; dy >= 0 && w < nw; w++)
				want.push_back(rule_addr(layer_cfg, sprite_cfg[k].tile, dy, w));
		end
		if (served.size() != want.size())
			flag_mismatch("served address count", served.size(), want.size());
		foreach (served[i]) begin
			hit = -1;
			foreach (want[j])
				if (hit < 0 && want[j] == served[i])
					hit = j;
			if (hit < 0)
				flag_error($sformatf("bus read of 0x%0h is not a row word of line %0d", served[i], y));
			else
				want.delete(hit);
		end
		check_count++;
	endtask

	task automatic sweep_line(input int y);
		for (int x = 0; x < 64; x++) begin
			@(posedge clk);
			pix_req <= 1'b1;
			pix_x <= x;
			exp_q.push_back(ref_pixel(sprite_cfg, layer_cfg, y, x));
			cyc_q.push_back(cycle + 1);  // the cycle in which this query is presented.
		end
		@(posedge clk);
		pix_req <= 1'b0;
		repeat (2) @(negedge clk);
		if (exp_q.size() != 0) begin
			flag_error($sformatf("%0d queries on line %0d got no answer", exp_q.size(), y));
			exp_q.delete();
			cyc_q.delete();
		end
	endtask

	task automatic run_line(input int y);
		int n;
		@(posedge clk);
		served.delete();
		line_y <= y;
		line_start <= 1'b1;
		@(posedge clk);
		line_start <= 1'b0;
		n = 0;
		@(negedge clk);
		while (!line_ready && n < LINE_CYCLES) begin
			@(negedge clk);
			n++;
		end
		if (!line_ready)
			flag_error($sformatf("line_ready did not rise within %0d cycles on line %0d", n, y));
		check_served(y);
		sweep_line(y);
	endtask

	always @(posedge clk)
		cycle <= cycle + 1;

	// memory model with a random stall before each answer.
	always @(posedge clk) begin
		if (!rst_n) begin
			bus_rdy <= 1'b0;
			stall <= 0;
		end else if (bus_req.vld && bus_rdy) begin
			served.push_back(bus_req.addr);  // the transfer completes on this edge.
			bus_rdy <= 1'b0;
			stall <= $unsigned($random(seed)) % 4;
		end else if (bus_req.vld && stall == 0) begin
			bus_rdy <= 1'b1;
			bus_data <= mem_word(bus_req.addr);
		end else if (bus_req.vld) begin
			stall <= stall - 1;
		end
	end

	always @(negedge clk) begin : compare
		sprite_pkg::pix_out_t e;
		int c;
		if (pix_vld) begin
			if (exp_q.size() == 0) begin
				flag_error("pix_vld rose with no query pending");
			end else begin
				e = exp_q.pop_front();
				c = cyc_q.pop_front();
				resp_count++;
				check_count++;
				if (cycle != c + 1)
					flag_mismatch("pix_vld cycle", cycle, c + 1);
				if (pix_out.hit !== e.hit)
					flag_mismatch("pix_out.hit", pix_out.hit, e.hit);
				if (pix_out.index !== e.index)
					flag_mismatch("pix_out.index", pix_out.index, e.index);
				if (pix_out.color !== e.color)
					flag_mismatch("pix_out.color", pix_out.color, e.color);
			end
		end
	end

	initial begin : watchdog
		repeat (2 * N_LINES * LINE_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run hung", 2 * N_LINES * LINE_CYCLES);
		$display("Test failed");
		$finish;
	end

	initial begin : stimulus
		int base;
		int resp0;
		line_start = 1'b0;
		line_y = '0;
		pix_req = 1'b0;
		pix_x = '0;
		bus_rdy = 1'b0;
		bus_data = '0;
		layer_cfg = '0;
		foreach (sprite_cfg[k])
			sprite_cfg[k] = '{pos_x: 0, pos_y: 900, tile: 0};

		base = err_count;
		repeat (7) begin
			@(negedge clk);
			if (bus_req.vld !== 1'b0)
				flag_mismatch("bus_req.vld", bus_req.vld, 0);
			if (line_ready !== 1'b0)
				flag_mismatch("line_ready", line_ready, 0);
			if (pix_vld !== 1'b0)
				flag_mismatch("pix_vld", pix_vld, 0);
			check_count++;
		end
		$display("test 1 reset state: %0d errors", err_count - base);

		base = err_count;
		set_layer(0, 0);
		place(0, 10, 20, 3);
		run_line(23);
		$display("test 2 single 8 pixel sprite: %0d errors", err_count - base);

		base = err_count;
		set_layer(1, 0);
		place(0, 8, 30, 1);
		place(1, 14, 32, 2);
		place(2, 20, 28, 7);
		place(3, 40, 500, 9);
		run_line(34);
		$display("test 3 overlapping sprites: %0d errors", err_count - base);

		base = err_count;
		set_layer(1, 1);
		place(0, 30, 40, 5);
		run_line(47);
		@(posedge clk);
		place(0, 0, 40, 5);
		place(1, 12, 44, 6);
		place(2, 24, 36, 200);
		place(3, 40, 41, 255);
		run_line(50);
		$display("test 4 16 pixel sprites under stalls: %0d errors", err_count - base);

		base = err_count;
		set_layer(0, 1);
		place(0, 5, 10, 11);
		place(1, 20, 60, 12);
		place(2, 35, 62, 13);
		place(3, 50, 300, 14);
		run_line(5);
		run_line(64);
		run_line(12);
		$display("test 5 off-line sprites and fetch counts: %0d errors", err_count - base);

		base = err_count;
		set_layer(1, 0);
		place(0, 0, 0, 1);
		place(1, 6, 2, 2);
		place(2, 12, 4, 3);
		place(3, 18, 6, 4);
		resp0 = resp_count;
		run_line(8);
		if (resp_count - resp0 != 64)
			flag_mismatch("pix_vld count", resp_count - resp0, 64);
		$display("test 6 back-to-back queries: %0d errors", err_count - base);

		if (u_sprite_engine.u_asserts.fail_count != 0)
			flag_error($sformatf("%0d bound assertions failed during the run",
				u_sprite_engine.u_asserts.fail_count));

		$display("6 tests, %0d checks, %0d errors", check_count, err_count);
		if (err_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- project.f
+incdir+source
source/sprite_pkg.sv
source/sprite_agu.sv
source/sprite_lane.sv
source/sprite_blend.sv
source/sprite_engine.sv
bench/sprite_clkgen.sv
bench/sprite_asserts.sv
bench/sprite_tb.sv

//--- Bender.yml
package:
  name: sprite_engine

sources:
  - include_dirs:
      - source
    files:
      - source/sprite_pkg.sv
      - source/sprite_agu.sv
      - source/sprite_lane.sv
      - source/sprite_blend.sv
      - source/sprite_engine.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - bench/sprite_clkgen.sv
      - bench/sprite_asserts.sv
      - bench/sprite_tb.sv
